//--- adpcma_cfg.svh
/* core sizing for the ADPCM-A playback core
   lane count, channels per lane, decoder width, credit depths */
`default_nettype none

`ifndef ADPCMA_CFG_SVH
`define ADPCMA_CFG_SVH

// decoder lanes in the array
`define ADPCMA_LANES 2

// one channel per ring stage, so this is fixed at 6
`define ADPCMA_CH_PER_LANE 6

// total channels seen by the host
`define ADPCMA_CHANNELS (`ADPCMA_LANES * `ADPCMA_CH_PER_LANE)

// 12-bit signal plus one overflow bit
`define ADPCMA_SIGW 13

// command queue depth, same as host credits at reset
`define ADPCMA_CMD_CREDITS 4

// sample credits the sink grants at reset
`define ADPCMA_OUT_CREDITS 2

`endif

`default_nettype wire

//--- adpcma_cmd_pkg.sv
/* host command types
   opcode enum and channel index */
`default_nettype none

package adpcma_cmd_pkg;

    // command opcodes
    typedef enum logic [1:0] {
        // queue a nibble for the channel
        op_data    = 2'd0,
        // zero state and step, then enable
        op_key_on  = 2'd1,
        // stop taking nibbles, hold the state
        op_key_off = 2'd2
    } cmd_op_e;

    // channel number, lane*6 + slot
    typedef logic [3:0] chan_t;

endpackage

`default_nettype wire

//--- adpcma_mix_pkg.sv
/* mixer types
   FSM states and frame accumulator */
`default_nettype none

package adpcma_mix_pkg;

    // accumulate six cycles, then one emit cycle
    typedef enum logic {
        mix_accum = 1'b0,
        mix_emit  = 1'b1
    } mix_state_e;

    // enough headroom for 12 full-scale channels
    typedef logic signed [19:0] mix_acc_t;

endpackage

`default_nettype wire

//--- adpcma_step_lut.sv
/* ADPCM-A step size table
   registered increment for a step index and a nibble magnitude */
`timescale 1ns/1ps
`default_nettype none

module adpcma_step_lut (
    input  wire logic       clk,
    input  wire logic       rst_n,
    input  wire logic [5:0] step,
    input  wire logic [2:0] mag,
    output logic      [11:0] inc
);

    logic [10:0] size;
    logic [14:0] prod;

    // 49 step sizes, roughly 10% apart
    always_comb begin
        case (step)
            6'd0:    size = 11'd16;
            6'd1:    size = 11'd17;
            6'd2:    size = 11'd19;
            6'd3:    size = 11'd21;
            6'd4:    size = 11'd23;
            6'd5:    size = 11'd25;
            6'd6:    size = 11'd28;
            6'd7:    size = 11'd31;
            6'd8:    size = 11'd34;
            6'd9:    size = 11'd37;
            6'd10:   size = 11'd41;
            6'd11:   size = 11'd45;
            6'd12:   size = 11'd50;
            6'd13:   size = 11'd55;
            6'd14:   size = 11'd60;
            6'd15:   size = 11'd66;
            6'd16:   size = 11'd73;
            6'd17:   size = 11'd80;
            6'd18:   size = 11'd88;
            6'd19:   size = 11'd97;
            6'd20:   size = 11'd107;
            6'd21:   size = 11'd118;
            6'd22:   size = 11'd130;
            6'd23:   size = 11'd143;
            6'd24:   size = 11'd157;
            6'd25:   size = 11'd173;
            6'd26:   size = 11'd190;
            6'd27:   size = 11'd209;
            6'd28:   size = 11'd230;
            6'd29:   size = 11'd253;
            6'd30:   size = 11'd279;
            6'd31:   size = 11'd307;
            6'd32:   size = 11'd337;
            6'd33:   size = 11'd371;
            6'd34:   size = 11'd408;
            6'd35:   size = 11'd449;
            6'd36:   size = 11'd494;
            6'd37:   size = 11'd544;
            6'd38:   size = 11'd598;
            6'd39:   size = 11'd658;
            6'd40:   size = 11'd724;
            6'd41:   size = 11'd796;
            6'd42:   size = 11'd876;
            6'd43:   size = 11'd963;
            6'd44:   size = 11'd1060;
            6'd45:   size = 11'd1166;
            6'd46:   size = 11'd1282;
            6'd47:   size = 11'd1411;
            6'd48:   size = 11'd1552;
            // the ring never steps past 48
            default: size = 11'd0;
        endcase
        // size * (2*mag + 1), largest is 1552*15
        prod = size * {mag, 1'b1};
    end

    // divide by 8 on the way into the register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inc <= '0;
        end else begin
            inc <= prod[14:3];
        end
    end

endmodule

`default_nettype wire

//--- adpcma_decoder_lane.sv
/* ADPCM-A decoder lane
   six-stage ring, one channel per stage, step adaptation and clamp */
`timescale 1ns/1ps
`include "adpcma_cfg.svh"
`default_nettype none

module adpcma_decoder_lane (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic        [3:0]  data,
    input  wire logic               chon,
    input  wire logic               clr,
    output logic signed      [15:0] pcm
);

    localparam int SIGW  = `ADPCMA_SIGW;
    localparam int SHIFT = 16 - SIGW + 1;
    localparam logic signed [SIGW-1:0] MAX_POS = {2'b00, {(SIGW-2){1'b1}}};
    localparam logic signed [SIGW-1:0] MAX_NEG = {2'b11, {(SIGW-2){1'b0}}};

    // channel state, x1 is the ring input
    logic signed [SIGW-1:0] x1, x2, x3, x4, x5, x6;
    logic        [5:0]      step1, step2, step3, step4, step5, step6;
    logic                   chon2, chon3, chon4;
    logic                   sign2, sign3;
    logic        [5:0]      step_addr2;
    logic        [2:0]      mag2;
    logic        [11:0]     inc3;
    logic signed [SIGW-1:0] inc3_long;
    logic signed [SIGW-1:0] inc4;
    logic        [5:0]      step_next;
    logic        [5:0]      step_adapt;

    // output taps stage II, one behind the input
    assign pcm = $signed({{(16-SIGW){x2[SIGW-1]}}, x2}) <<< SHIFT;

    // step update from the nibble magnitude
    always_comb begin
        casez (data[2:0])
            3'b0??:  step_next = (step1 == 6'd0) ? 6'd0 : step1 - 6'd1;
            3'b100:  step_next = step1 + 6'd2;
            3'b101:  step_next = step1 + 6'd5;
            3'b110:  step_next = step1 + 6'd7;
            default: step_next = step1 + 6'd9;
        endcase
        step_adapt = (step_next > 6'd48) ? 6'd48 : step_next;
    end

    // address in stage II, increment back in stage III
    adpcma_step_lut step_lut_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .step  (step_addr2),
        .mag   (mag2),
        .inc   (inc3)
    );

    assign inc3_long = $signed({{(SIGW-12){1'b0}}, inc3});

    // sign and lookup path
    always_ff @(posedge clk) begin
        sign2      <= data[3];
        step_addr2 <= step1;
        mag2       <= data[2:0];
        sign3      <= sign2;
        inc4       <= sign3 ? -inc3_long : inc3_long;
    end

    // the ring itself
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x1    <= '0;
            x2    <= '0;
            x3    <= '0;
            x4    <= '0;
            x5    <= '0;
            x6    <= '0;
            step1 <= '0;
            step2 <= '0;
            step3 <= '0;
            step4 <= '0;
            step5 <= '0;
            step6 <= '0;
            chon2 <= 1'b0;
            chon3 <= 1'b0;
            chon4 <= 1'b0;
        end else begin
            // I: clear or adapt
            x2    <= clr ? '0 : x1;
            step2 <= clr ? 6'd0 : (chon ? step_adapt : step1);
            chon2 <= chon;
            // II and III: wait on the table
            x3    <= x2;
            step3 <= step2;
            chon3 <= chon2;
            x4    <= x3;
            step4 <= step3;
            chon4 <= chon3;
            // IV: add signed increment
            x5    <= chon4 ? x4 + inc4 : x4;
            step5 <= step4;
            // V: clamp to 12 bits
            if (x5 > MAX_POS) begin
                x6 <= MAX_POS;
            end else if (x5 < MAX_NEG) begin
                x6 <= MAX_NEG;
            end else begin
                x6 <= x5;
            end
            step6 <= step5;
            // VI: back to the front
            x1    <= x6;
            step1 <= step6;
        end
    end

endmodule

`default_nettype wire

//--- adpcma_feeder.sv
/* command queue and channel feeder
   credit return, pending nibbles per channel, slot counter, key state */
`timescale 1ns/1ps
`include "adpcma_cfg.svh"
`default_nettype none

module adpcma_feeder (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    cmd_valid,
    input  wire adpcma_cmd_pkg::cmd_op_e cmd_op,
    input  wire adpcma_cmd_pkg::chan_t   cmd_chan,
    input  wire logic [3:0]              cmd_nibble,
    output logic                         cmd_credit,
    output logic [3:0]                   data [`ADPCMA_LANES],
    output logic [`ADPCMA_LANES-1:0]     chon,
    output logic [`ADPCMA_LANES-1:0]     clr
);

    localparam int DEPTH = `ADPCMA_CMD_CREDITS;
    localparam int LANES = `ADPCMA_LANES;
    localparam int CPL   = `ADPCMA_CH_PER_LANE;
    localparam int NCH   = `ADPCMA_CHANNELS;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    adpcma_cmd_pkg::cmd_op_e op_q   [DEPTH];
    adpcma_cmd_pkg::chan_t   chan_q [DEPTH];
    logic [3:0]              nib_q  [DEPTH];
    logic [PW-1:0]           wr_ptr, rd_ptr;
    logic [CW-1:0]           count;

    // per channel state
    logic [NCH-1:0]        key_on, pend_valid, clr_pend;
    logic [3:0]            pend_nib [NCH];
    logic [2:0]            slot;
    adpcma_cmd_pkg::chan_t lane_ch [LANES];

    adpcma_cmd_pkg::chan_t head_chan;
    logic head_ok, head_data, head_key, key_seen;
    logic pop_data, pop_key, pop, store;

    assign head_chan = chan_q[rd_ptr];
    // out-of-range channels are dropped at the head
    assign head_ok   = head_chan < NCH;
    assign head_data = (count != '0) && (op_q[rd_ptr] == adpcma_cmd_pkg::op_data);
    assign head_key  = (count != '0) && (op_q[rd_ptr] != adpcma_cmd_pkg::op_data);
    // data waits for a free pending slot
    assign pop_data  = head_data && !(head_ok && pend_valid[head_chan]);
    // key ops sit one cycle at the head
    assign pop_key   = head_key && key_seen;
    assign pop       = pop_data || pop_key;
    assign store     = pop_data && head_ok && key_on[head_chan];
    assign cmd_credit = pop;

    // lane l serves channel l*6 + slot
    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            lane_ch[l] = adpcma_cmd_pkg::chan_t'(l * CPL) + adpcma_cmd_pkg::chan_t'(slot);
            data[l]    = pend_nib[lane_ch[l]];
            clr[l]     = clr_pend[lane_ch[l]];
            // hold the nibble back while a clear is due
            chon[l]    = key_on[lane_ch[l]] && pend_valid[lane_ch[l]] && !clr_pend[lane_ch[l]];
        end
    end

    // queue storage and pending nibbles
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            op_q[wr_ptr]   <= cmd_op;
            chan_q[wr_ptr] <= cmd_chan;
            nib_q[wr_ptr]  <= cmd_nibble;
        end
        if (store) begin
            pend_nib[head_chan] <= nib_q[rd_ptr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            slot       <= '0;
            key_seen   <= 1'b0;
            key_on     <= '0;
            pend_valid <= '0;
            clr_pend   <= '0;
        end else begin
            slot     <= (slot == 3'(CPL - 1)) ? 3'd0 : slot + 3'd1;
            key_seen <= head_key && !pop_key;
            count    <= count + CW'(cmd_valid) - CW'(pop);
            if (cmd_valid) begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // lanes consume in their slot
            for (int l = 0; l < LANES; l++) begin
                if (chon[l]) pend_valid[lane_ch[l]] <= 1'b0;
                if (clr[l]) clr_pend[lane_ch[l]] <= 1'b0;
            end
            // head command wins over the slot update
            if (store) begin
                pend_valid[head_chan] <= 1'b1;
            end
            if (pop_key && head_ok) begin
                if (op_q[rd_ptr] == adpcma_cmd_pkg::op_key_on) begin
                    key_on[head_chan]   <= 1'b1;
                    clr_pend[head_chan] <= 1'b1;
                end else begin
                    key_on[head_chan]   <= 1'b0;
                end
                pend_valid[head_chan] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- adpcma_mixer.sv
/* frame mixer
   six-cycle sum over all lanes, 16-bit saturation, credit-limited output */
`timescale 1ns/1ps
`include "adpcma_cfg.svh"
`default_nettype none

module adpcma_mixer (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic signed [15:0] pcm [`ADPCMA_LANES],
    input  wire logic               sample_credit,
    output logic                    sample_valid,
    output logic signed      [15:0] sample
);

    localparam int LANES = `ADPCMA_LANES;
    localparam int CPL   = `ADPCMA_CH_PER_LANE;
    localparam int CRED  = `ADPCMA_OUT_CREDITS;
    localparam int CRW   = $clog2(CRED + 1);
    localparam adpcma_mix_pkg::mix_acc_t SAT_MAX = 20'sd32767;
    localparam adpcma_mix_pkg::mix_acc_t SAT_MIN = -20'sd32768;

    adpcma_mix_pkg::mix_state_e state;
    adpcma_mix_pkg::mix_acc_t   acc, lane_sum;
    logic [2:0]                 cnt;
    logic [CRW-1:0]             credits;
    logic signed [15:0]         sat;
    logic                       emit;

    // this cycle's channels from every lane
    always_comb begin
        lane_sum = '0;
        for (int l = 0; l < LANES; l++) begin
            lane_sum = lane_sum + adpcma_mix_pkg::mix_acc_t'(pcm[l]);
        end
    end

    always_comb begin
        if (acc > SAT_MAX) begin
            sat = 16'sh7fff;
        end else if (acc < SAT_MIN) begin
            sat = -16'sh8000;
        end else begin
            sat = acc[15:0];
        end
    end

    // no credit means the frame is lost
    assign emit = (state == adpcma_mix_pkg::mix_emit) && (credits != '0);

    always_ff @(posedge clk) begin
        if (emit) sample <= sat;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= adpcma_mix_pkg::mix_accum;
            cnt          <= '0;
            acc          <= '0;
            credits      <= CRW'(CRED);
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= emit;
            credits      <= credits - CRW'(emit) + CRW'(sample_credit);
            case (state)
                adpcma_mix_pkg::mix_accum: begin
                    acc <= acc + lane_sum;
                    if (cnt == 3'(CPL - 1)) begin
                        state <= adpcma_mix_pkg::mix_emit;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 3'd1;
                    end
                end
                default: begin
                    // emit cycle also opens the next frame
                    acc   <= lane_sum;
                    cnt   <= 3'd1;
                    state <= adpcma_mix_pkg::mix_accum;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- adpcma_top.sv
/* ADPCM-A playback core top level
   feeder, decoder lane array and mixer */
`timescale 1ns/1ps
`include "adpcma_cfg.svh"
`default_nettype none

module adpcma_top (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    cmd_valid,
    input  wire adpcma_cmd_pkg::cmd_op_e cmd_op,
    input  wire adpcma_cmd_pkg::chan_t   cmd_chan,
    input  wire logic [3:0]              cmd_nibble,
    output logic                         cmd_credit,
    input  wire logic                    sample_credit,
    output logic                         sample_valid,
    output logic signed [15:0]           sample
);

    // one set per lane
    logic [3:0]               lane_data [`ADPCMA_LANES];
    logic [`ADPCMA_LANES-1:0] lane_chon;
    logic [`ADPCMA_LANES-1:0] lane_clr;
    logic signed [15:0]       lane_pcm  [`ADPCMA_LANES];

    adpcma_feeder feeder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_chan   (cmd_chan),
        .cmd_nibble (cmd_nibble),
        .cmd_credit (cmd_credit),
        .data       (lane_data),
        .chon       (lane_chon),
        .clr        (lane_clr)
    );

    for (genvar l = 0; l < `ADPCMA_LANES; l++) begin : g_lane
        adpcma_decoder_lane lane_inst (
            .clk   (clk),
            .rst_n (rst_n),
            .data  (lane_data[l]),
            .chon  (lane_chon[l]),
            .clr   (lane_clr[l]),
            .pcm   (lane_pcm[l])
        );
    end

    adpcma_mixer mixer_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .pcm           (lane_pcm),
        .sample_credit (sample_credit),
        .sample_valid  (sample_valid),
        .sample        (sample)
    );

endmodule

`default_nettype wire

//--- adpcma_tb_ref.svh
/* testbench reference model
   step size table, step adaptation, nibble decode and frame mix */
`default_nettype none

`ifndef ADPCMA_TB_REF_SVH
`define ADPCMA_TB_REF_SVH

// 49 ADPCM-A step sizes
function automatic int step_size(input int step);
    int sizes [49];
    sizes = '{16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66,
              73, 80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253,
              279, 307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876,
              963, 1060, 1166, 1282, 1411, 1552};
    return sizes[step];
endfunction

// small magnitudes step down, large ones step up
function automatic int adapt_step(input int step, input logic [3:0] nib);
    int stepped;
    case (nib[2:0])
        3'd4:    stepped = step + 2;
        3'd5:    stepped = step + 5;
        3'd6:    stepped = step + 7;
        3'd7:    stepped = step + 9;
        default: stepped = step - 1;
    endcase
    if (stepped < 0) stepped = 0;
    if (stepped > 48) stepped = 48;
    return stepped;
endfunction

// new channel value, increment taken from the old step
function automatic int decode_nibble(input int x, input int step, input logic [3:0] nib);
    int inc;
    int sum;
    int span;
    int lim;
    span = 1 << `ADPCMA_SIGW;
    lim  = 1 << (`ADPCMA_SIGW - 2);
    inc  = (step_size(step) * (2 * int'(nib[2:0]) + 1)) / 8;
    sum  = nib[3] ? x - inc : x + inc;
    // signal width includes one overflow bit, sum wraps there
    sum = sum & (span - 1);
    if (sum >= span / 2) sum = sum - span;
    // then the 12-bit clamp
    if (sum > lim - 1) begin
        sum = lim - 1;
    end else if (sum < -lim) begin
        sum = -lim;
    end
    return sum;
endfunction

// each channel shifted left by 4, summed, saturated to 16 bits
function automatic int mix_frame(input int xs [`ADPCMA_CHANNELS]);
    int total;
    total = 0;
    foreach (xs[i]) total += xs[i] * 16;
    if (total > 32767) begin
        total = 32767;
    end else if (total < -32768) begin
        total = -32768;
    end
    return total;
endfunction

`endif

`default_nettype wire

//--- adpcma_tb.sv
/* ADPCM-A core testbench
   host and sink models, directed and random tests, assertions */
`timescale 1ns/1ps
`include "adpcma_cfg.svh"
`include "adpcma_tb_ref.svh"
`default_nettype none

module adpcma_tb;

    localparam int NCH     = `ADPCMA_CHANNELS;
    // tests need about 3000 cycles, twice that as the limit
    localparam int TIMEOUT = 6000;

    logic                    clk, rst_n, cmd_valid, cmd_credit;
    logic                    sample_credit, sample_valid;
    adpcma_cmd_pkg::cmd_op_e cmd_op;
    adpcma_cmd_pkg::chan_t   cmd_chan;
    logic [3:0]              cmd_nibble;
    logic signed [15:0]      sample;

    // host side, words are {op, chan, nibble}
    logic [9:0] cmd_fifo [$];
    logic [9:0] cmd_word;
    int         host_credits, cmds_sent, credit_pulses;
    // sink side
    int         samples_seen, last_sample, credits_owed, last_valid_cycle, seen;
    bit         withhold;
    // model state per channel
    int         model_x [NCH];
    int         model_step [NCH];
    bit         model_on [NCH];
    int         cycles, errors, tests, tests_failed, test_start_errors;

    adpcma_top adpcma_top_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_valid     (cmd_valid),
        .cmd_op        (cmd_op),
        .cmd_chan      (cmd_chan),
        .cmd_nibble    (cmd_nibble),
        .cmd_credit    (cmd_credit),
        .sample_credit (sample_credit),
        .sample_valid  (sample_valid),
        .sample        (sample)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // host driver, credit return counted before spending
    always @(posedge clk) begin
        #10;
        if (rst_n && cmd_credit) begin
            host_credits++;
            credit_pulses++;
        end
        if (rst_n && cmd_fifo.size() != 0 && host_credits > 0) begin
            cmd_word   = cmd_fifo.pop_front();
            cmd_valid  = 1'b1;
            cmd_op     = adpcma_cmd_pkg::cmd_op_e'(cmd_word[9:8]);
            cmd_chan   = cmd_word[7:4];
            cmd_nibble = cmd_word[3:0];
            host_credits--;
            cmds_sent++;
        end else begin
            cmd_valid = 1'b0;
        end
    end

    // sink, one credit back per sample unless held
    always @(posedge clk) begin
        #10;
        if (rst_n && sample_valid) begin
            // at most one sample per frame
            assert (samples_seen == 0 || cycles - last_valid_cycle >= 6) else begin
                $display("protocol error at %0t ns: two samples within one frame", $time);
                errors++;
            end
            samples_seen++;
            last_sample      = sample;
            last_valid_cycle = cycles;
            credits_owed++;
        end
        if (!withhold && credits_owed > 0) begin
            sample_credit = 1'b1;
            credits_owed--;
        end else begin
            sample_credit = 1'b0;
        end
    end

    reset_quiet: assert property (@(posedge clk) !rst_n |-> !sample_valid && !cmd_credit)
        else begin
            $display("protocol error at %0t ns: output active during reset", $time);
            errors++;
        end

    valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else begin
            $display("protocol error at %0t ns: sample_valid longer than a cycle", $time);
            errors++;
        end

    // negative means the host sent without credit, too many means stray pulses
    credit_range: assert property (@(posedge clk) disable iff (!rst_n)
        host_credits >= 0 && host_credits <= `ADPCMA_CMD_CREDITS)
        else begin
            $display("protocol error at %0t ns: host credits out of range", $time);
            errors++;
        end

    task automatic check_value(input string what, input int got, input int exp);
        assert (got == exp) else begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    // queue a command, model follows in queue order
    task automatic send_cmd(input adpcma_cmd_pkg::cmd_op_e op, input int ch,
                            input logic [3:0] nib);
        cmd_fifo.push_back({2'(op), 4'(ch), nib});
        case (op)
            adpcma_cmd_pkg::op_key_on: begin
                model_x[ch]    = 0;
                model_step[ch] = 0;
                model_on[ch]   = 1'b1;
            end
            adpcma_cmd_pkg::op_key_off: begin
                model_on[ch] = 1'b0;
            end
            default: begin
                // keyed-off channels drop their nibbles
                if (model_on[ch]) begin
                    model_x[ch]    = decode_nibble(model_x[ch], model_step[ch], nib);
                    model_step[ch] = adapt_step(model_step[ch], nib);
                end
            end
        endcase
    endtask

    task automatic wait_sample();
        int start;
        int waited;
        start  = samples_seen;
        waited = 0;
        while (samples_seen == start && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (samples_seen == start) begin
            $display("error at %0t ns: no sample arrived within 20 cycles", $time);
            errors++;
        end
    endtask

    // drain, idle two frames, compare a whole frame
    task automatic check_mix(input string what);
        int waited;
        waited = 0;
        while ((cmd_fifo.size() != 0 || host_credits != `ADPCMA_CMD_CREDITS)
               && waited < 2000) begin
            @(posedge clk);
            waited++;
        end
        if (waited >= 2000) begin
            $display("error at %0t ns: command queue did not drain", $time);
            errors++;
        end
        repeat (24) @(posedge clk);
        wait_sample();
        wait_sample();
        check_value(what, last_sample, mix_frame(model_x));
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == test_start_errors) begin
            $display("test %0d %s: passed", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin
        void'($urandom(75));
        rst_n         = 1'b1;
        cmd_valid     = 1'b0;
        cmd_op        = adpcma_cmd_pkg::op_data;
        cmd_chan      = '0;
        cmd_nibble    = '0;
        sample_credit = 1'b0;
        withhold      = 1'b0;
        host_credits  = `ADPCMA_CMD_CREDITS;
        // falling edge starts the async reset
        #5 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #10 rst_n = 1'b1;

        // reset state mixes to silence
        wait_sample();
        check_value("first sample", last_sample, 0);
        wait_sample();
        check_value("second sample", last_sample, 0);
        finish_test("reset");

        // one channel in lane 1
        send_cmd(adpcma_cmd_pkg::op_key_on, 7, 4'd0);
        repeat (20) send_cmd(adpcma_cmd_pkg::op_data, 7, 4'($urandom));
        check_mix("single channel sample");
        finish_test("single channel");

        // random streams, round robin over both lanes
        for (int ch = 0; ch < NCH; ch++) send_cmd(adpcma_cmd_pkg::op_key_on, ch, 4'd0);
        repeat (8) begin
            for (int ch = 0; ch < NCH; ch++) begin
                send_cmd(adpcma_cmd_pkg::op_data, ch, 4'($urandom));
            end
        end
        check_mix("random mix sample");
        // magnitude 4 never wraps, every channel climbs to the clamp
        for (int ch = 0; ch < NCH; ch++) send_cmd(adpcma_cmd_pkg::op_key_on, ch, 4'd0);
        repeat (20) begin
            for (int ch = 0; ch < NCH; ch++) send_cmd(adpcma_cmd_pkg::op_data, ch, 4'd4);
        end
        check_mix("saturated mix sample");
        check_value("positive clamp", last_sample, 32767);
        finish_test("all channels");

        for (int ch = 0; ch < NCH; ch++) send_cmd(adpcma_cmd_pkg::op_key_on, ch, 4'd0);
        check_mix("sample after key on");
        repeat (6) begin
            send_cmd(adpcma_cmd_pkg::op_data, 2, 4'($urandom));
            send_cmd(adpcma_cmd_pkg::op_data, 8, 4'($urandom));
        end
        check_mix("two channel sample");
        // ch 2 frozen, ch 8 keeps moving
        send_cmd(adpcma_cmd_pkg::op_key_off, 2, 4'd0);
        repeat (6) begin
            send_cmd(adpcma_cmd_pkg::op_data, 2, 4'($urandom));
            send_cmd(adpcma_cmd_pkg::op_data, 8, 4'($urandom));
        end
        check_mix("frozen channel sample");
        send_cmd(adpcma_cmd_pkg::op_key_on, 8, 4'd0);
        check_mix("rekeyed channel sample");
        finish_test("key control");

        check_value("credit pulses", credit_pulses, cmds_sent);
        // sink stops returning credits, decoding goes on
        withhold = 1'b1;
        seen     = samples_seen;
        repeat (6) send_cmd(adpcma_cmd_pkg::op_data, 5, 4'($urandom));
        repeat (60) @(posedge clk);
        assert (samples_seen - seen <= `ADPCMA_OUT_CREDITS) else begin
            $display("error at %0t ns: %0d samples sent without credit", $time,
                     samples_seen - seen);
            errors++;
        end
        withhold = 1'b0;
        seen     = samples_seen;
        repeat (60) @(posedge clk);
        assert (samples_seen - seen >= 8) else begin
            $display("error at %0t ns: samples did not resume after credit return", $time);
            errors++;
        end
        check_mix("sample after credit return");
        check_value("credit pulses", credit_pulses, cmds_sent);
        finish_test("credits");

        $display("%0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- adpcma.f
+incdir+.
adpcma_cmd_pkg.sv
adpcma_mix_pkg.sv
adpcma_step_lut.sv
adpcma_decoder_lane.sv
adpcma_feeder.sv
adpcma_mixer.sv
adpcma_top.sv
adpcma_tb.sv

//--- Makefile
# Verilator build and run for the ADPCM-A core testbench

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module adpcma_tb \
		-f adpcma.f --Mdir obj_dir -o adpcma_sim

# pass only if the log holds the pass line
run: compile
	./obj_dir/adpcma_sim > sim.log 2>&1; cat sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
